/* hdl/backend_cfg_pkg.sv */
`default_nettype none

package backend_cfg_pkg;

	// datapath width
	localparam int XLEN = 64;

	// architectural register file
	localparam int REG_NUM = 32;
	localparam int REG_AW  = $clog2(REG_NUM);

	// reorder buffer, depth must stay a power of two
	localparam int ROB_DEPTH = 8;
	localparam int ROB_AW    = $clog2(ROB_DEPTH);

endpackage

`default_nettype wire

/* hdl/micro_op_pkg.sv */
`default_nettype none

package micro_op_pkg;

	import backend_cfg_pkg::*;

	// field widths
	localparam int UOP_IMM_W = 12;
	localparam int UOP_OP_W  = 4;

	// field positions, imm at the bottom and unit select on top
	localparam int UOP_IMM_LSB = 0;
	localparam int UOP_USE_IMM = UOP_IMM_LSB + UOP_IMM_W;
	localparam int UOP_RS2_LSB = UOP_USE_IMM + 1;
	localparam int UOP_RS1_LSB = UOP_RS2_LSB + REG_AW;
	localparam int UOP_RD_LSB  = UOP_RS1_LSB + REG_AW;
	localparam int UOP_OP_LSB  = UOP_RD_LSB + REG_AW;
	localparam int UOP_UNIT    = UOP_OP_LSB + UOP_OP_W;
	localparam int UOP_W       = UOP_UNIT + 1;

	// unit select values
	localparam logic UNIT_ADD = 1'b0;
	localparam logic UNIT_LC  = 1'b1;

	// logic/compare func codes
	localparam logic [2:0] LC_AND  = 3'd0;
	localparam logic [2:0] LC_OR   = 3'd1;
	localparam logic [2:0] LC_XOR  = 3'd2;
	localparam logic [2:0] LC_SLT  = 3'd3;
	localparam logic [2:0] LC_SLTU = 3'd4;

	// op field, read differently by each unit
	typedef union packed {
		struct packed {
			logic [1:0] rsvd;
			logic       is_word;
			logic       is_sub;
		} add;
		struct packed {
			logic       rsvd;
			logic [2:0] func;
		} lc;
	} op_u;

endpackage

`default_nettype wire

/* hdl/dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

module dispatch (
	input  wire                                 i_clk,
	input  wire                                 i_rst,
	input  wire [micro_op_pkg::UOP_W-1:0]       i_uop,
	input  wire                                 i_instr_empty,
	input  wire [backend_cfg_pkg::REG_NUM-1:0]  i_pending,
	input  wire [backend_cfg_pkg::XLEN-1:0]     i_rs1_data,
	input  wire [backend_cfg_pkg::XLEN-1:0]     i_rs2_data,
	input  wire                                 i_rob_full,
	input  wire [backend_cfg_pkg::ROB_AW-1:0]   i_rob_tag,
	output logic                                o_instr_pop,
	output logic [backend_cfg_pkg::REG_AW-1:0]  o_rs1_addr,
	output logic [backend_cfg_pkg::REG_AW-1:0]  o_rs2_addr,
	output logic                                o_alloc_valid,
	output logic [backend_cfg_pkg::REG_AW-1:0]  o_alloc_rd,
	output logic                                o_rob_alloc,
	output logic [backend_cfg_pkg::REG_AW-1:0]  o_rob_rd,
	output logic                                o_add_valid,
	output micro_op_pkg::op_u                   o_add_op,
	output logic [backend_cfg_pkg::XLEN-1:0]    o_add_a,
	output logic [backend_cfg_pkg::XLEN-1:0]    o_add_b,
	output logic [backend_cfg_pkg::ROB_AW-1:0]  o_add_tag,
	output logic                                o_lc_valid,
	output micro_op_pkg::op_u                   o_lc_op,
	output logic [backend_cfg_pkg::XLEN-1:0]    o_lc_a,
	output logic [backend_cfg_pkg::XLEN-1:0]    o_lc_b,
	output logic [backend_cfg_pkg::ROB_AW-1:0]  o_lc_tag
);

	import backend_cfg_pkg::*;
	import micro_op_pkg::*;

	logic                 unit_sel;
	op_u                  op;
	logic [REG_AW-1:0]    rd;
	logic [REG_AW-1:0]    rs1;
	logic [REG_AW-1:0]    rs2;
	logic                 use_imm;
	logic [UOP_IMM_W-1:0] imm;
	logic [XLEN-1:0]      opnd_b;
	logic                 rs1_busy;
	logic                 rs2_busy;
	logic                 rd_busy;
	logic                 to_add;
	logic                 to_lc;

	assign unit_sel = i_uop[UOP_UNIT];
	assign op       = i_uop[UOP_OP_LSB +: UOP_OP_W];
	assign rd       = i_uop[UOP_RD_LSB +: REG_AW];
	assign rs1      = i_uop[UOP_RS1_LSB +: REG_AW];
	assign rs2      = i_uop[UOP_RS2_LSB +: REG_AW];
	assign use_imm  = i_uop[UOP_USE_IMM];
	assign imm      = i_uop[UOP_IMM_LSB +: UOP_IMM_W];

	assign o_rs1_addr = rs1;
	assign o_rs2_addr = rs2;

	// x0 never has its pending bit set, so rs checks need no x0 guard
	assign rs1_busy = i_pending[rs1];
	assign rs2_busy = !use_imm && i_pending[rs2];
	assign rd_busy  = (rd != '0) && i_pending[rd];

	assign o_instr_pop = !i_instr_empty && !i_rob_full && !rs1_busy && !rs2_busy && !rd_busy;

	assign o_alloc_valid = o_instr_pop;
	assign o_alloc_rd    = rd;
	assign o_rob_alloc   = o_instr_pop;
	assign o_rob_rd      = rd;

	assign opnd_b = use_imm ? {{(XLEN-UOP_IMM_W){imm[UOP_IMM_W-1]}}, imm} : i_rs2_data;

	assign to_add = o_instr_pop && (unit_sel == UNIT_ADD);
	assign to_lc  = o_instr_pop && (unit_sel == UNIT_LC);

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_add_valid <= 1'b0;
			o_lc_valid  <= 1'b0;
		end else begin
			o_add_valid <= to_add;
			o_lc_valid  <= to_lc;
		end
	end

	always_ff @(posedge i_clk) begin
		if (to_add) begin
			o_add_op  <= op;
			o_add_a   <= i_rs1_data;
			o_add_b   <= opnd_b;
			o_add_tag <= i_rob_tag;
		end
		if (to_lc) begin
			o_lc_op  <= op;
			o_lc_a   <= i_rs1_data;
			o_lc_b   <= opnd_b;
			o_lc_tag <= i_rob_tag;
		end
	end

endmodule

`default_nettype wire

/* hdl/reg_scoreboard.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_scoreboard (
	input  wire                                 i_clk,
	input  wire                                 i_rst,
	input  wire [backend_cfg_pkg::REG_AW-1:0]   i_rs1_addr,
	input  wire [backend_cfg_pkg::REG_AW-1:0]   i_rs2_addr,
	input  wire                                 i_alloc_valid,
	input  wire [backend_cfg_pkg::REG_AW-1:0]   i_alloc_rd,
	input  wire                                 i_commit_valid,
	input  wire [backend_cfg_pkg::REG_AW-1:0]   i_commit_rd,
	input  wire [backend_cfg_pkg::XLEN-1:0]     i_commit_data,
	output logic [backend_cfg_pkg::XLEN-1:0]    o_rs1_data,
	output logic [backend_cfg_pkg::XLEN-1:0]    o_rs2_data,
	output logic [backend_cfg_pkg::REG_NUM-1:0] o_pending
);

	import backend_cfg_pkg::*;

	// x0 has no storage
	logic [XLEN-1:0]    regs [1:REG_NUM-1];
	logic [REG_NUM-1:0] pending;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			for (int i = 1; i < REG_NUM; i++) begin
				regs[i] <= '0;
			end
		end else if (i_commit_valid && (i_commit_rd != '0)) begin
			regs[i_commit_rd] <= i_commit_data;
		end
	end

	// allocate and commit never hit the same register in one cycle
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			pending <= '0;
		end else begin
			if (i_commit_valid) begin
				pending[i_commit_rd] <= 1'b0;
			end
			if (i_alloc_valid && (i_alloc_rd != '0)) begin
				pending[i_alloc_rd] <= 1'b1;
			end
		end
	end

	assign o_rs1_data = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
	assign o_rs2_data = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];
	assign o_pending  = pending;

endmodule

`default_nettype wire

/* hdl/adder_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module adder_unit (
	input  wire                                 i_clk,
	input  wire                                 i_rst,
	input  wire                                 i_valid,
	input  wire micro_op_pkg::op_u              i_op,
	input  wire [backend_cfg_pkg::XLEN-1:0]     i_a,
	input  wire [backend_cfg_pkg::XLEN-1:0]     i_b,
	input  wire [backend_cfg_pkg::ROB_AW-1:0]   i_tag,
	output logic                                o_res_valid,
	output logic [backend_cfg_pkg::XLEN-1:0]    o_res,
	output logic [backend_cfg_pkg::ROB_AW-1:0]  o_res_tag
);

	import backend_cfg_pkg::*;

	logic [XLEN-1:0] sum;
	logic [XLEN-1:0] res;

	assign sum = i_op.add.is_sub ? (i_a - i_b) : (i_a + i_b);

	// word ops keep the low half and sign-extend it
	assign res = i_op.add.is_word ? {{(XLEN-32){sum[31]}}, sum[31:0]} : sum;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_res_valid <= 1'b0;
		end else begin
			o_res_valid <= i_valid;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_valid) begin
			o_res     <= res;
			o_res_tag <= i_tag;
		end
	end

endmodule

`default_nettype wire

/* hdl/logcmp_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module logcmp_unit (
	input  wire                                 i_clk,
	input  wire                                 i_rst,
	input  wire                                 i_valid,
	input  wire micro_op_pkg::op_u              i_op,
	input  wire [backend_cfg_pkg::XLEN-1:0]     i_a,
	input  wire [backend_cfg_pkg::XLEN-1:0]     i_b,
	input  wire [backend_cfg_pkg::ROB_AW-1:0]   i_tag,
	output logic                                o_res_valid,
	output logic [backend_cfg_pkg::XLEN-1:0]    o_res,
	output logic [backend_cfg_pkg::ROB_AW-1:0]  o_res_tag
);

	import backend_cfg_pkg::*;
	import micro_op_pkg::*;

	logic [XLEN-1:0]   res;
	logic              s1_valid;
	logic [XLEN-1:0]   s1_res;
	logic [ROB_AW-1:0] s1_tag;

	always_comb begin
		case (i_op.lc.func)
			LC_AND:  res = i_a & i_b;
			LC_OR:   res = i_a | i_b;
			LC_XOR:  res = i_a ^ i_b;
			LC_SLT:  res = {{(XLEN-1){1'b0}}, $signed(i_a) < $signed(i_b)};
			LC_SLTU: res = {{(XLEN-1){1'b0}}, i_a < i_b};
			default: res = '0;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			s1_valid    <= 1'b0;
			o_res_valid <= 1'b0;
		end else begin
			s1_valid    <= i_valid;
			o_res_valid <= s1_valid;
		end
	end

	// second stage only retimes, two ops may be in flight
	always_ff @(posedge i_clk) begin
		if (i_valid) begin
			s1_res <= res;
			s1_tag <= i_tag;
		end
		if (s1_valid) begin
			o_res     <= s1_res;
			o_res_tag <= s1_tag;
		end
	end

endmodule

`default_nettype wire

/* hdl/reorder_commit.sv */
`timescale 1ns/1ps
`default_nettype none

module reorder_commit (
	input  wire                                 i_clk,
	input  wire                                 i_rst,
	input  wire                                 i_alloc,
	input  wire [backend_cfg_pkg::REG_AW-1:0]   i_alloc_rd,
	input  wire                                 i_add_valid,
	input  wire [backend_cfg_pkg::ROB_AW-1:0]   i_add_tag,
	input  wire [backend_cfg_pkg::XLEN-1:0]     i_add_res,
	input  wire                                 i_lc_valid,
	input  wire [backend_cfg_pkg::ROB_AW-1:0]   i_lc_tag,
	input  wire [backend_cfg_pkg::XLEN-1:0]     i_lc_res,
	output logic                                o_full,
	output logic [backend_cfg_pkg::ROB_AW-1:0]  o_tail_tag,
	output logic                                o_commit_valid,
	output logic [backend_cfg_pkg::REG_AW-1:0]  o_commit_rd,
	output logic [backend_cfg_pkg::XLEN-1:0]    o_commit_data
);

	import backend_cfg_pkg::*;

	logic [REG_AW-1:0]    rob_rd  [ROB_DEPTH];
	logic [XLEN-1:0]      rob_res [ROB_DEPTH];
	logic [ROB_DEPTH-1:0] done;
	logic [ROB_AW-1:0]    head;
	logic [ROB_AW-1:0]    tail;
	logic [ROB_AW:0]      count;
	logic                 retire;

	// head retires once its result is back
	assign retire = (count != '0) && done[head];

	assign o_full     = (count == ROB_DEPTH);
	assign o_tail_tag = tail;

	assign o_commit_valid = retire;
	assign o_commit_rd    = rob_rd[head];
	assign o_commit_data  = rob_res[head];

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			if (i_alloc) begin
				tail <= tail + 1'b1;
			end
			if (retire) begin
				head <= head + 1'b1;
			end
			case ({i_alloc, retire})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// tags in flight never equal the free tail slot
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			done <= '0;
		end else begin
			if (i_alloc) begin
				done[tail] <= 1'b0;
			end
			if (i_add_valid) begin
				done[i_add_tag] <= 1'b1;
			end
			if (i_lc_valid) begin
				done[i_lc_tag] <= 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_alloc) begin
			rob_rd[tail] <= i_alloc_rd;
		end
		if (i_add_valid) begin
			rob_res[i_add_tag] <= i_add_res;
		end
		if (i_lc_valid) begin
			rob_res[i_lc_tag] <= i_lc_res;
		end
	end

endmodule

`default_nettype wire

/* hdl/backend.sv */
`timescale 1ns/1ps
`default_nettype none

module backend (
	input  wire                                i_clk,
	input  wire                                i_rst,
	input  wire [micro_op_pkg::UOP_W-1:0]      i_uop,
	input  wire                                i_instr_empty,
	output wire                                o_instr_pop,
	output wire                                o_commit_valid,
	output wire [backend_cfg_pkg::REG_AW-1:0]  o_commit_rd,
	output wire [backend_cfg_pkg::XLEN-1:0]    o_commit_data
);

	import backend_cfg_pkg::*;
	import micro_op_pkg::*;

	wire [REG_AW-1:0]  rs1_addr;
	wire [REG_AW-1:0]  rs2_addr;
	wire [XLEN-1:0]    rs1_data;
	wire [XLEN-1:0]    rs2_data;
	wire [REG_NUM-1:0] pending;
	wire               alloc_valid;
	wire [REG_AW-1:0]  alloc_rd;

	wire               rob_alloc;
	wire [REG_AW-1:0]  rob_rd;
	wire               rob_full;
	wire [ROB_AW-1:0]  rob_tag;

	wire               add_valid;
	wire op_u          add_op;
	wire [XLEN-1:0]    add_a;
	wire [XLEN-1:0]    add_b;
	wire [ROB_AW-1:0]  add_tag;
	wire               lc_valid;
	wire op_u          lc_op;
	wire [XLEN-1:0]    lc_a;
	wire [XLEN-1:0]    lc_b;
	wire [ROB_AW-1:0]  lc_tag;

	// unit results back to the reorder buffer
	wire               add_res_valid;
	wire [XLEN-1:0]    add_res;
	wire [ROB_AW-1:0]  add_res_tag;
	wire               lc_res_valid;
	wire [XLEN-1:0]    lc_res;
	wire [ROB_AW-1:0]  lc_res_tag;

	dispatch i_dispatch (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_uop(i_uop),
		.i_instr_empty(i_instr_empty),
		.i_pending(pending),
		.i_rs1_data(rs1_data),
		.i_rs2_data(rs2_data),
		.i_rob_full(rob_full),
		.i_rob_tag(rob_tag),
		.o_instr_pop(o_instr_pop),
		.o_rs1_addr(rs1_addr),
		.o_rs2_addr(rs2_addr),
		.o_alloc_valid(alloc_valid),
		.o_alloc_rd(alloc_rd),
		.o_rob_alloc(rob_alloc),
		.o_rob_rd(rob_rd),
		.o_add_valid(add_valid),
		.o_add_op(add_op),
		.o_add_a(add_a),
		.o_add_b(add_b),
		.o_add_tag(add_tag),
		.o_lc_valid(lc_valid),
		.o_lc_op(lc_op),
		.o_lc_a(lc_a),
		.o_lc_b(lc_b),
		.o_lc_tag(lc_tag)
	);

	reg_scoreboard i_reg_scoreboard (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_rs1_addr(rs1_addr),
		.i_rs2_addr(rs2_addr),
		.i_alloc_valid(alloc_valid),
		.i_alloc_rd(alloc_rd),
		.i_commit_valid(o_commit_valid),
		.i_commit_rd(o_commit_rd),
		.i_commit_data(o_commit_data),
		.o_rs1_data(rs1_data),
		.o_rs2_data(rs2_data),
		.o_pending(pending)
	);

	adder_unit i_adder_unit (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_valid(add_valid),
		.i_op(add_op),
		.i_a(add_a),
		.i_b(add_b),
		.i_tag(add_tag),
		.o_res_valid(add_res_valid),
		.o_res(add_res),
		.o_res_tag(add_res_tag)
	);

	logcmp_unit i_logcmp_unit (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_valid(lc_valid),
		.i_op(lc_op),
		.i_a(lc_a),
		.i_b(lc_b),
		.i_tag(lc_tag),
		.o_res_valid(lc_res_valid),
		.o_res(lc_res),
		.o_res_tag(lc_res_tag)
	);

	reorder_commit i_reorder_commit (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_alloc(rob_alloc),
		.i_alloc_rd(rob_rd),
		.i_add_valid(add_res_valid),
		.i_add_tag(add_res_tag),
		.i_add_res(add_res),
		.i_lc_valid(lc_res_valid),
		.i_lc_tag(lc_res_tag),
		.i_lc_res(lc_res),
		.o_full(rob_full),
		.o_tail_tag(rob_tag),
		.o_commit_valid(o_commit_valid),
		.o_commit_rd(o_commit_rd),
		.o_commit_data(o_commit_data)
	);

endmodule

`default_nettype wire

/* test/tb_backend.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_backend;

	import backend_cfg_pkg::*;
	import micro_op_pkg::*;

	logic              i_clk;
	logic              i_rst;
	logic [UOP_W-1:0]  i_uop;
	logic              i_instr_empty;
	wire               o_instr_pop;
	wire               o_commit_valid;
	wire [REG_AW-1:0]  o_commit_rd;
	wire [XLEN-1:0]    o_commit_data;

	integer            seed;
	int                mismatch_count;
	int                fail_count;
	logic [UOP_W-1:0]  uop_q[$];
	logic [REG_AW-1:0] exp_rd_q[$];
	logic [XLEN-1:0]   exp_data_q[$];
	logic [XLEN-1:0]   model_regs [REG_NUM];
	logic [REG_AW-1:0] want_rd;
	logic [XLEN-1:0]   want_data;

	backend i_backend (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_uop(i_uop),
		.i_instr_empty(i_instr_empty),
		.o_instr_pop(o_instr_pop),
		.o_commit_valid(o_commit_valid),
		.o_commit_rd(o_commit_rd),
		.o_commit_data(o_commit_data)
	);

	always #2 i_clk = ~i_clk;

	task automatic check_data(input string name, input logic [XLEN-1:0] got,
			input logic [XLEN-1:0] want);
		if (got !== want) begin
			mismatch_count++;
			$display("Mismatch %s: got %h, expected %h", name, got, want);
		end
	endtask

	task automatic check_rd(input string name, input logic [REG_AW-1:0] got,
			input logic [REG_AW-1:0] want);
		if (got !== want) begin
			mismatch_count++;
			$display("Mismatch %s: got %h, expected %h", name, got, want);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic want);
		if (got !== want) begin
			mismatch_count++;
			$display("Mismatch %s: got %h, expected %h", name, got, want);
		end
	endtask

	// external FIFO model with the head presented 1 ns after the edge
	always @(posedge i_clk) begin
		if (!i_rst && o_instr_pop === 1'b1) begin
			if (i_instr_empty) begin
				fail_count++;
				$display("Pop asserted while the FIFO was empty");
			end else begin
				uop_q.delete(0);
			end
		end
		#1;
		if (uop_q.size() == 0) begin
			i_instr_empty = 1'b1;
			i_uop = '0;
		end else begin
			i_instr_empty = 1'b0;
			i_uop = uop_q[0];
		end
	end

	// commits must follow queue order
	always @(posedge i_clk) begin
		if (!i_rst && o_commit_valid === 1'b1) begin
			if (exp_rd_q.size() == 0) begin
				fail_count++;
				$display("Commit to rd %0d arrived with no op outstanding", o_commit_rd);
			end else begin
				want_rd = exp_rd_q.pop_front();
				want_data = exp_data_q.pop_front();
				check_rd("o_commit_rd", o_commit_rd, want_rd);
				check_data("o_commit_data", o_commit_data, want_data);
			end
		end
	end

	function automatic op_u aop(input logic is_sub, input logic is_word);
		op_u op;
		op = '0;
		op.add.is_sub = is_sub;
		op.add.is_word = is_word;
		return op;
	endfunction

	function automatic op_u lop(input logic [2:0] func);
		op_u op;
		op = '0;
		op.lc.func = func;
		return op;
	endfunction

	function automatic logic [UOP_W-1:0] make_uop(input logic unit, input op_u op,
			input logic [REG_AW-1:0] rd, input logic [REG_AW-1:0] rs1,
			input logic [REG_AW-1:0] rs2, input logic use_imm,
			input logic [UOP_IMM_W-1:0] imm);
		logic [UOP_W-1:0] w;
		w = '0;
		w[UOP_UNIT] = unit;
		w[UOP_OP_LSB +: UOP_OP_W] = op;
		w[UOP_RD_LSB +: REG_AW] = rd;
		w[UOP_RS1_LSB +: REG_AW] = rs1;
		w[UOP_RS2_LSB +: REG_AW] = rs2;
		w[UOP_USE_IMM] = use_imm;
		w[UOP_IMM_LSB +: UOP_IMM_W] = imm;
		return w;
	endfunction

	function automatic logic [XLEN-1:0] expect_result(input logic unit, input op_u op,
			input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
		logic [XLEN-1:0]   sum;
		logic signed [31:0] low;
		logic [XLEN-1:0]   res;
		if (unit == UNIT_ADD) begin
			sum = op.add.is_sub ? a - b : a + b;
			low = sum[31:0];
			if (op.add.is_word)
				res = low;
			else
				res = sum;
		end else begin
			case (op.lc.func)
				LC_AND:  res = a & b;
				LC_OR:   res = a | b;
				LC_XOR:  res = a ^ b;
				// with differing signs the negative one is smaller
				LC_SLT:  res = (a[XLEN-1] != b[XLEN-1]) ? a[XLEN-1] : (a < b);
				LC_SLTU: res = (a < b);
				default: res = '0;
			endcase
		end
		return res;
	endfunction

	task automatic queue_op(input logic unit, input op_u op, input logic [REG_AW-1:0] rd,
			input logic [REG_AW-1:0] rs1, input logic [REG_AW-1:0] rs2,
			input logic use_imm, input logic [UOP_IMM_W-1:0] imm);
		logic signed [UOP_IMM_W-1:0] simm;
		logic [XLEN-1:0]             b;
		logic [XLEN-1:0]             res;
		simm = imm;
		if (use_imm)
			b = simm;
		else
			b = model_regs[rs2];
		res = expect_result(unit, op, model_regs[rs1], b);
		if (rd != '0)
			model_regs[rd] = res;
		exp_rd_q.push_back(rd);
		exp_data_q.push_back(res);
		uop_q.push_back(make_uop(unit, op, rd, rs1, rs2, use_imm, imm));
	endtask

	task automatic wait_drained(input string what, input int limit);
		int cycles;
		cycles = 0;
		while ((exp_rd_q.size() != 0 || uop_q.size() != 0) && cycles < limit) begin
			@(negedge i_clk);
			cycles++;
		end
		if (exp_rd_q.size() != 0 || uop_q.size() != 0) begin
			fail_count++;
			$display("Timeout in %s: %0d commits never came", what, exp_rd_q.size());
			exp_rd_q.delete();
			exp_data_q.delete();
			uop_q.delete();
		end
	endtask

	task automatic idle_after_reset();
		repeat (20) begin
			@(negedge i_clk);
			check_flag("o_instr_pop", o_instr_pop, 1'b0);
			check_flag("o_commit_valid", o_commit_valid, 1'b0);
		end
	endtask

	task automatic adder_ops();
		@(negedge i_clk);
		queue_op(UNIT_ADD, aop(1'b0, 1'b0), 5'd1, 5'd0, 5'd0, 1'b1, 12'h7ff);
		queue_op(UNIT_ADD, aop(1'b1, 1'b0), 5'd2, 5'd0, 5'd0, 1'b1, 12'h001);
		queue_op(UNIT_ADD, aop(1'b0, 1'b0), 5'd3, 5'd1, 5'd2, 1'b0, 12'h000);
		queue_op(UNIT_ADD, aop(1'b1, 1'b0), 5'd4, 5'd1, 5'd2, 1'b0, 12'h000);
		// doubling brings x9 up to 0x7ff00000
		queue_op(UNIT_ADD, aop(1'b0, 1'b0), 5'd9, 5'd0, 5'd0, 1'b1, 12'h7ff);
		repeat (20)
			queue_op(UNIT_ADD, aop(1'b0, 1'b0), 5'd9, 5'd9, 5'd9, 1'b0, 12'h000);
		queue_op(UNIT_ADD, aop(1'b0, 1'b1), 5'd10, 5'd9, 5'd9, 1'b0, 12'h000);
		queue_op(UNIT_ADD, aop(1'b0, 1'b0), 5'd11, 5'd9, 5'd9, 1'b0, 12'h000);
		queue_op(UNIT_ADD, aop(1'b1, 1'b1), 5'd12, 5'd0, 5'd9, 1'b0, 12'h000);
		queue_op(UNIT_ADD, aop(1'b0, 1'b1), 5'd5, 5'd2, 5'd0, 1'b1, 12'h001);
		wait_drained("adder ops", 400);
	endtask

	task automatic logcmp_ops();
		@(negedge i_clk);
		queue_op(UNIT_ADD, aop(1'b0, 1'b0), 5'd13, 5'd0, 5'd0, 1'b1, 12'h005);
		queue_op(UNIT_ADD, aop(1'b1, 1'b0), 5'd14, 5'd0, 5'd0, 1'b1, 12'h003);
		queue_op(UNIT_LC, lop(LC_SLT), 5'd15, 5'd14, 5'd13, 1'b0, 12'h000);
		queue_op(UNIT_LC, lop(LC_SLTU), 5'd16, 5'd14, 5'd13, 1'b0, 12'h000);
		queue_op(UNIT_LC, lop(LC_SLT), 5'd17, 5'd13, 5'd0, 1'b1, 12'hfff);
		queue_op(UNIT_LC, lop(LC_SLTU), 5'd17, 5'd13, 5'd0, 1'b1, 12'hfff);
		queue_op(UNIT_LC, lop(LC_AND), 5'd18, 5'd9, 5'd14, 1'b0, 12'h000);
		queue_op(UNIT_LC, lop(LC_OR), 5'd19, 5'd9, 5'd13, 1'b0, 12'h000);
		queue_op(UNIT_LC, lop(LC_XOR), 5'd20, 5'd14, 5'd0, 1'b1, 12'h5a5);
		queue_op(UNIT_LC, lop(LC_AND), 5'd20, 5'd20, 5'd0, 1'b1, 12'h0f0);
		wait_drained("logic/compare ops", 200);
	endtask

	task automatic dependency_chain();
		@(negedge i_clk);
		queue_op(UNIT_ADD, aop(1'b0, 1'b0), 5'd21, 5'd0, 5'd0, 1'b1, 12'h064);
		queue_op(UNIT_LC, lop(LC_XOR), 5'd22, 5'd21, 5'd13, 1'b0, 12'h000);
		queue_op(UNIT_ADD, aop(1'b0, 1'b0), 5'd23, 5'd22, 5'd21, 1'b0, 12'h000);
		queue_op(UNIT_LC, lop(LC_SLTU), 5'd24, 5'd22, 5'd23, 1'b0, 12'h000);
		// WAW to x25 across both units and a read back
		queue_op(UNIT_LC, lop(LC_OR), 5'd25, 5'd0, 5'd0, 1'b1, 12'h001);
		queue_op(UNIT_ADD, aop(1'b0, 1'b0), 5'd25, 5'd0, 5'd0, 1'b1, 12'h002);
		queue_op(UNIT_ADD, aop(1'b0, 1'b0), 5'd26, 5'd25, 5'd0, 1'b1, 12'h000);
		wait_drained("dependency chain", 200);
	endtask

	task automatic random_mix(input int count);
		logic [31:0] r;
		logic [31:0] s;
		logic [2:0]  func;
		for (int n = 0; n < count; n++) begin
			r = $random(seed);
			s = $random(seed);
			func = r[3:1] % 5;
			if (r[0] == UNIT_LC)
				queue_op(UNIT_LC, lop(func), r[8:4], r[13:9], r[18:14], r[19], s[11:0]);
			else
				queue_op(UNIT_ADD, aop(r[20], r[21]), r[8:4], r[13:9], r[18:14], r[19],
					s[11:0]);
		end
	endtask

	task automatic cross_unit_order();
		@(negedge i_clk);
		queue_op(UNIT_LC, lop(LC_XOR), 5'd27, 5'd9, 5'd14, 1'b0, 12'h000);
		queue_op(UNIT_ADD, aop(1'b0, 1'b0), 5'd28, 5'd0, 5'd0, 1'b1, 12'h007);
		queue_op(UNIT_ADD, aop(1'b0, 1'b0), 5'd29, 5'd0, 5'd0, 1'b1, 12'h008);
		queue_op(UNIT_ADD, aop(1'b1, 1'b0), 5'd30, 5'd1, 5'd0, 1'b1, 12'h003);
		wait_drained("cross-unit order", 200);
		@(negedge i_clk);
		random_mix(40);
		wait_drained("random mix", 800);
	endtask

	task automatic x0_destination();
		@(negedge i_clk);
		queue_op(UNIT_ADD, aop(1'b0, 1'b0), 5'd0, 5'd13, 5'd0, 1'b1, 12'h064);
		// the x0 result retires before anything reads x0
		wait_drained("x0 destination", 100);
		@(negedge i_clk);
		queue_op(UNIT_LC, lop(LC_OR), 5'd31, 5'd0, 5'd0, 1'b0, 12'h000);
		queue_op(UNIT_ADD, aop(1'b0, 1'b0), 5'd30, 5'd0, 5'd0, 1'b1, 12'h009);
		wait_drained("x0 read back", 100);
	endtask

	initial begin
		seed = 32'hc4c8;
		mismatch_count = 0;
		fail_count = 0;
		i_clk = 1'b0;
		i_rst = 1'b1;
		i_uop = '0;
		i_instr_empty = 1'b1;
		for (int i = 0; i < REG_NUM; i++)
			model_regs[i] = '0;
		repeat (5) @(posedge i_clk);
		#1 i_rst = 1'b0;

		idle_after_reset();
		adder_ops();
		logcmp_ops();
		dependency_chain();
		cross_unit_order();
		x0_destination();

		$display("Errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
		if (mismatch_count == 0 && fail_count == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
hdl/backend_cfg_pkg.sv
hdl/micro_op_pkg.sv
hdl/dispatch.sv
hdl/reg_scoreboard.sv
hdl/adder_unit.sv
hdl/logcmp_unit.sv
hdl/reorder_commit.sv
hdl/backend.sv
test/tb_backend.sv

/* Bender.yml */
package:
  name: backend

sources:
  - files:
      - hdl/backend_cfg_pkg.sv
      - hdl/micro_op_pkg.sv
      - hdl/dispatch.sv
      - hdl/reg_scoreboard.sv
      - hdl/adder_unit.sv
      - hdl/logcmp_unit.sv
      - hdl/reorder_commit.sv
      - hdl/backend.sv
  - target: test
    files:
      - test/tb_backend.sv
